// File: project.f
+incdir+design
design/trap_pkg.sv
design/seq_pkg.sv
design/seq_fsm.sv
design/trap_unit.sv
design/fetch_redirect.sv
design/rv_controller.sv
sim/rv_controller_sva.sv
sim/rv_controller_tb.sv

// File: sim/rv_controller_tb.sv
// testbench for the RISC-V sequencing controller: start, redirects, traps and data phases
`default_nettype none

`include "ctl_cfg.svh"

module rv_controller_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import trap_pkg::*;
    import seq_pkg::*;

    typedef enum logic [3:0] {
        K_JUMP, K_MRET, K_JMIS, K_ECALL, K_EBREAK,
        K_TIMER, K_TIMER_BLK, K_LOAD, K_LOAD_MIS, K_STORE_MIS
    } kind_e;

    // one table row: what to do, a random address, expected cause, vectored mtvec
    typedef struct packed {
        kind_e                   kind;
        logic [`CTL_PC_BITS-1:0] addr;
        logic [3:0]              code;
        logic                    vec;
    } entry_t;

    localparam int NUM_ENTRIES = 15;
    localparam int CLK_PERIOD  = 40;

    logic                    clk;
    logic                    reset_n;
    logic                    start;
    logic [`CTL_PC_BITS-1:0] start_addr;
    logic                    mem_read_ack;
    dec_info_t               dec;
    jump_req_t               jump;
    logic                    mret_active;
    logic                    load_done;
    logic                    store_done;
    logic [`CTL_XLEN-1:0]    mem_addr;
    logic [`CTL_PC_BITS-1:0] pc_in;
    mtvec_u                  mtvec_in;
    logic [`CTL_PC_BITS-1:0] mepc_in;
    trap_req_t               req;
    logic                    timer_triggered;
    logic                    fetch_init;
    logic [`CTL_PC_BITS-1:0] fetch_start_addr;
    logic                    fetch_next;
    logic                    exe_enable;
    logic                    data_access_enable;
    logic                    csr_mret_active;
    trap_report_t            report;
    logic                    paused;

    entry_t table_q [NUM_ENTRIES];
    int     errors;
    int     tests_failed;

    rv_controller uut (.*);

    bind rv_controller rv_controller_sva sva_inst (
        .clk, .reset_n, .state(u_seq_fsm.state), .activate(report.activate),
        .fetch_init, .paused
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // watchdog, 60 cycles per test
    initial begin
        #((NUM_ENTRIES + 1) * 60 * CLK_PERIOD);
        $display("watchdog expired, the tests did not finish in time");
        $display("*** FAILED ***");
        $finish;
    end

    // ======================================================================
    // helpers
    // ======================================================================
    task automatic cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic flag_mismatch(input string msg);
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic note_failure(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    task automatic clear_inputs();
        jump            = '0;
        mret_active     = 1'b0;
        req             = '0;
        timer_triggered = 1'b0;
        load_done       = 1'b0;
        store_done      = 1'b0;
        dec.load        = 1'b0;
        dec.store       = 1'b0;
    endtask

    // direct mode uses the whole word, vectored mode spaces entries 4 bytes apart
    function automatic logic [31:0] expected_vector(input logic [31:0] raw,
                                                    input logic [3:0] code);
        if (raw[1:0] == 2'b00) begin
            return raw;
        end
        return {raw[31:2], 2'b00} + ({28'd0, code} << 2);
    endfunction

    // run until execute enable, then one cycle on into the execute decision
    task automatic wait_exec();
        int n;
        n = 0;
        while (!exe_enable && n < 20) begin
            cycle();
            n++;
        end
        if (!exe_enable) note_failure("timed out waiting for execute enable");
        cycle();
        if (!data_access_enable) flag_mismatch("data access not enabled in execute");
    endtask

    task automatic check_redirect(input logic [31:0] addr);
        cycle();
        clear_inputs();
        if (!fetch_init) flag_mismatch("fetch_init missing after redirect");
        if (fetch_start_addr !== addr)
            flag_mismatch($sformatf("restart address %h, expected %h", fetch_start_addr, addr));
    endtask

    task automatic check_trap(input logic [3:0] code, input logic intr, input logic [31:0] pc,
                              input logic [31:0] addr, input bit check_addr);
        logic [31:0] vec;
        cycle();
        clear_inputs();
        if (report.activate) flag_mismatch("activate one cycle early");
        cycle();
        if (!report.activate) flag_mismatch("activate missing two cycles after decision");
        if (report.code !== code)
            flag_mismatch($sformatf("code %0d, expected %0d", report.code, code));
        if (report.is_interrupt !== intr) flag_mismatch("wrong interrupt flag");
        if (report.pc !== pc) flag_mismatch($sformatf("pc %h, expected %h", report.pc, pc));
        if (check_addr && report.addr !== addr)
            flag_mismatch($sformatf("addr %h, expected %h", report.addr, addr));
        vec = expected_vector(mtvec_in.raw, code);
        cycle();
        if (report.activate) flag_mismatch("activate longer than one cycle");
        if (!fetch_init || fetch_start_addr !== vec)
            flag_mismatch($sformatf("vector restart %h, expected %h", fetch_start_addr, vec));
    endtask

    // core model for a load or store, with a short random wait before done
    task automatic run_data(input entry_t e);
        logic [31:0] pc_begin;
        int          n;
        dec.load  = (e.kind != K_STORE_MIS);
        dec.store = (e.kind == K_STORE_MIS);
        mem_addr  = (e.kind == K_LOAD) ? {e.addr[31:2], 2'b00} : {e.addr[31:1], 1'b1};
        cycle();
        n = 0;
        while (!data_access_enable && n < 8) begin
            cycle();
            n++;
        end
        if (!data_access_enable) note_failure("the data phase never started");
        clear_inputs();
        pc_begin = pc_in;
        cycle();
        pc_in = $urandom & ~32'd3;
        if (e.kind != K_LOAD) begin
            req.misalign = 1'b1;
            check_trap(e.code, 1'b0, pc_begin, mem_addr, 1'b1);
        end else begin
            repeat ($urandom_range(2, 0)) cycle();
            load_done = 1'b1;
            #1;
            if (!fetch_next) flag_mismatch("no fetch_next when the load completes");
            cycle();
            clear_inputs();
            n = 0;
            while (!exe_enable && n < 8) begin
                if (report.activate) flag_mismatch("trap raised by an aligned load");
                cycle();
                n++;
            end
            if (!exe_enable) note_failure("no return to execute after the load");
        end
    endtask

    task automatic apply_entry(input entry_t e);
        logic [31:0] raw;
        raw          = $urandom;
        raw[1:0]     = e.vec ? 2'b01 : 2'b00;
        mtvec_in.raw = raw;
        pc_in        = $urandom & ~32'd3;
        wait_exec();
        case (e.kind)
            K_JUMP: begin
                jump.active = 1'b1;
                jump.target = {e.addr[31:2], 1'b0, e.addr[0]};
                check_redirect({e.addr[31:2], 2'b00});
            end
            K_MRET: begin
                mepc_in     = {e.addr[31:2], 2'b00};
                mret_active = 1'b1;
                #1;
                if (!csr_mret_active) flag_mismatch("csr_mret_active low during MRET");
                check_redirect(mepc_in);
            end
            K_JMIS: begin
                jump.active = 1'b1;
                jump.target = {e.addr[31:2], 1'b1, e.addr[0]};
                check_trap(e.code, 1'b0, pc_in, {e.addr[31:2], 2'b10}, 1'b1);
            end
            K_ECALL: begin
                req.ecall = 1'b1;
                check_trap(e.code, 1'b0, pc_in, '0, 1'b0);
            end
            K_EBREAK: begin
                req.ebreak = 1'b1;
                check_trap(e.code, 1'b0, pc_in, '0, 1'b0);
            end
            K_TIMER: begin
                timer_triggered = 1'b1;
                check_trap(e.code, 1'b1, pc_in + 32'd4, '0, 1'b0);
            end
            K_TIMER_BLK: begin
                timer_triggered = 1'b1;
                repeat (5) begin
                    cycle();
                    clear_inputs();
                    if (report.activate || fetch_init) flag_mismatch("blocked timer was taken");
                end
            end
            default: run_data(e);
        endcase
    endtask

    // ======================================================================
    // main sequence
    // ======================================================================
    initial begin
        int fails_before;
        void'($urandom(32'hf396));
        errors          = 0;
        tests_failed    = 0;
        clk             = 1'b0;
        reset_n         = 1'b0;
        start           = 1'b0;
        start_addr      = '0;
        mem_read_ack    = 1'b1;   // zero-wait instruction memory
        dec             = '{enable_out: 1'b1, load: 1'b0, store: 1'b0};
        jump            = '0;
        mret_active     = 1'b0;
        load_done       = 1'b0;
        store_done      = 1'b0;
        mem_addr        = '0;
        pc_in           = '0;
        mtvec_in        = '0;
        mepc_in         = '0;
        req             = '0;
        timer_triggered = 1'b0;
        table_q = '{
            '{K_JUMP, $urandom, 4'd0, 1'b0},     '{K_MRET, $urandom, 4'd0, 1'b0},
            '{K_JMIS, $urandom, 4'd0, 1'b0},     '{K_JMIS, $urandom, 4'd0, 1'b1},
            '{K_EBREAK, $urandom, 4'd3, 1'b1},   '{K_ECALL, $urandom, 4'd11, 1'b0},
            '{K_MRET, $urandom, 4'd0, 1'b0},     '{K_TIMER, $urandom, 4'd7, 1'b1},
            '{K_TIMER_BLK, $urandom, 4'd0, 1'b0}, '{K_MRET, $urandom, 4'd0, 1'b0},
            '{K_TIMER, $urandom, 4'd7, 1'b0},    '{K_MRET, $urandom, 4'd0, 1'b0},
            '{K_LOAD, $urandom, 4'd0, 1'b0},     '{K_LOAD_MIS, $urandom, 4'd4, 1'b0},
            '{K_STORE_MIS, $urandom, 4'd6, 1'b1}
        };
        repeat (5) @(posedge clk);
        #2;
        reset_n = 1'b1;

        // start from reset
        if (!paused) flag_mismatch("paused low after reset");
        if (fetch_init || fetch_next || exe_enable || data_access_enable || csr_mret_active)
            flag_mismatch("strobe high after reset");
        if (report !== '0 || fetch_start_addr !== '0)
            flag_mismatch("trap report or start address not zero after reset");
        cycle();
        start      = 1'b1;
        start_addr = $urandom | 32'd1;
        cycle();
        start = 1'b0;
        if (!fetch_init) flag_mismatch("fetch_init missing after start");
        if (fetch_start_addr !== {start_addr[31:1], 1'b0}) flag_mismatch("wrong start address");
        if (paused) flag_mismatch("paused still high after start");
        cycle();
        if (fetch_init) flag_mismatch("fetch_init longer than one cycle");
        if (errors != 0) tests_failed++;
        $display("test 0 START: %s", (errors == 0) ? "ok" : "failed");

        for (int i = 0; i < NUM_ENTRIES; i++) begin
            fails_before = errors;
            apply_entry(table_q[i]);
            if (errors != fails_before) tests_failed++;
            $display("test %0d %s: %s", i + 1, table_q[i].kind.name(),
                     (errors == fails_before) ? "ok" : "failed");
        end

        $display("summary: %0d tests, %0d failed, %0d check errors",
                 NUM_ENTRIES + 1, tests_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/rv_controller_sva.sv
// sequencing controller assertions: one-hot state, single-cycle trap and restart pulses
`default_nettype none

module rv_controller_sva (
    input logic                clk,
    input logic                reset_n,
    input seq_pkg::state_vec_t state,
    input logic                activate,
    input logic                fetch_init,
    input logic                paused
);

    timeunit 1ns;
    timeprecision 1ps;

    import seq_pkg::*;

    state_onehot: assert property (@(posedge clk) disable iff (!reset_n) $onehot(state))
        else $error("state vector is not one-hot");

    // trap report to the CSR file
    activate_single: assert property (
        @(posedge clk) disable iff (!reset_n) activate |=> !activate)
        else $error("trap activate lasted more than one cycle");

    restart_single: assert property (
        @(posedge clk) disable iff (!reset_n) fetch_init |=> !fetch_init)
        else $error("fetch_init high in two consecutive cycles");

    paused_idle: assert property (@(posedge clk) disable iff (!reset_n) paused |-> state[IDLE])
        else $error("paused high outside IDLE");

endmodule

`default_nettype wire

// File: design/rv_controller.sv
// RISC-V sequencing controller top: FSM, trap unit and fetch redirect
`default_nettype none

`include "ctl_cfg.svh"

module rv_controller (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     start,
    input  logic [`CTL_PC_BITS-1:0]  start_addr,
    input  logic                     mem_read_ack,
    input  seq_pkg::dec_info_t       dec,
    input  seq_pkg::jump_req_t       jump,
    input  logic                     mret_active,
    input  logic                     load_done,
    input  logic                     store_done,
    input  logic [`CTL_XLEN-1:0]     mem_addr,
    input  logic [`CTL_PC_BITS-1:0]  pc_in,
    input  trap_pkg::mtvec_u         mtvec_in,
    input  logic [`CTL_PC_BITS-1:0]  mepc_in,
    input  trap_pkg::trap_req_t      req,
    input  logic                     timer_triggered,
    output logic                     fetch_init,
    output logic [`CTL_PC_BITS-1:0]  fetch_start_addr,
    output logic                     fetch_next,
    output logic                     exe_enable,
    output logic                     data_access_enable,
    output logic                     csr_mret_active,
    output trap_pkg::trap_report_t   report,
    output logic                     paused
);

    import seq_pkg::*;

    fsm_ctl_t                ctl;
    logic                    trap_pending;
    logic                    int_block;
    logic                    fetch_active;
    logic                    first_exe;
    logic [`CTL_PC_BITS-1:0] vector;

    assign fetch_next      = ctl.fetch_enable;
    assign csr_mret_active = ctl.mret_init;

    seq_fsm u_seq_fsm (
        .clk, .reset_n, .start, .mem_read_ack, .dec, .jump, .mret_active,
        .load_done, .store_done, .timer_triggered, .trap_pending, .int_block,
        .fetch_active, .first_exe, .ctl, .exe_enable, .data_access_enable, .paused
    );

    trap_unit u_trap_unit (
        .clk, .reset_n, .ctl, .req, .jump_target(jump.target), .mret_active,
        .pc_in, .mem_addr, .mtvec_in, .fetch_init, .fetch_start_addr,
        .trap_pending, .int_block, .report, .vector
    );

    fetch_redirect u_fetch_redirect (
        .clk, .reset_n, .ctl, .start_addr, .jump_target(jump.target), .mepc_in,
        .vector, .mem_read_ack, .fetch_init, .fetch_start_addr, .fetch_active,
        .first_exe
    );

endmodule

`default_nettype wire

// File: design/fetch_redirect.sv
// fetch redirect: restart pulse and address, outstanding fetch and first execute flags
`default_nettype none

`include "ctl_cfg.svh"

module fetch_redirect (
    input  logic                     clk,
    input  logic                     reset_n,
    input  seq_pkg::fsm_ctl_t        ctl,
    input  logic [`CTL_PC_BITS-1:0]  start_addr,
    input  logic [`CTL_PC_BITS-1:0]  jump_target,
    input  logic [`CTL_PC_BITS-1:0]  mepc_in,
    input  logic [`CTL_PC_BITS-1:0]  vector,
    input  logic                     mem_read_ack,
    output logic                     fetch_init,
    output logic [`CTL_PC_BITS-1:0]  fetch_start_addr,
    output logic                     fetch_active,
    output logic                     first_exe
);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            fetch_init       <= 1'b0;
            fetch_start_addr <= '0;
            fetch_active     <= 1'b0;
            first_exe        <= 1'b0;
        end else begin
            fetch_init <= ctl.pc_init | ctl.jump_init | ctl.mret_init | ctl.trap_init;

            // halfword bit dropped on start and jump targets
            if (ctl.pc_init) begin
                fetch_start_addr <= {start_addr[`CTL_PC_BITS-1:1], 1'b0};
            end else if (ctl.jump_init) begin
                fetch_start_addr <= {jump_target[`CTL_PC_BITS-1:1], 1'b0};
            end else if (ctl.mret_init) begin
                fetch_start_addr <= mepc_in;
            end else if (ctl.trap_init) begin
                fetch_start_addr <= vector;
            end

            // a fetch is outstanding until its read acknowledge
            if (ctl.fetch_enable) begin
                fetch_active <= 1'b1;
            end else if (mem_read_ack) begin
                fetch_active <= 1'b0;
            end

            if (fetch_init) begin
                first_exe <= 1'b0;
            end else if (ctl.exe_enable) begin
                first_exe <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/trap_unit.sv
// trap unit: latches causes, encodes the cause code, captures PC and address, builds vector
`default_nettype none

`include "ctl_cfg.svh"

module trap_unit (
    input  logic                        clk,
    input  logic                        reset_n,
    input  seq_pkg::fsm_ctl_t           ctl,
    input  trap_pkg::trap_req_t         req,
    input  logic [`CTL_PC_BITS-1:0]     jump_target,
    input  logic                        mret_active,
    input  logic [`CTL_PC_BITS-1:0]     pc_in,
    input  logic [`CTL_XLEN-1:0]        mem_addr,
    input  trap_pkg::mtvec_u            mtvec_in,
    input  logic                        fetch_init,
    input  logic [`CTL_PC_BITS-1:0]     fetch_start_addr,
    output logic                        trap_pending,
    output logic                        int_block,
    output trap_pkg::trap_report_t      report,
    output logic [`CTL_PC_BITS-1:0]     vector
);

    import trap_pkg::*;

    localparam logic [`CTL_PC_BITS-1:0] INSTR_BYTES = 'd4;

    logic ecall_q;
    logic ebreak_q;
    logic jump_mis_q;
    logic align_q;
    logic load_q;
    logic timer_set_d1;
    logic timer_active;
    logic ecall_active;
    logic restart_pending;

    logic [`CTL_PC_BITS-1:0] pc_mem;
    logic [`CTL_XLEN-1:0]    vec_base;

    assign trap_pending = req.ecall | req.ebreak | req.misalign | align_q;
    assign int_block    = timer_active | ecall_active;

    // PC of the instruction that opened the data phase
    always_ff @(posedge clk) begin
        if (ctl.mem_begin) begin
            pc_mem <= pc_in;
        end
    end

    // ==================================================================
    // sticky causes and interrupt state
    // ==================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ecall_q         <= 1'b0;
            ebreak_q        <= 1'b0;
            jump_mis_q      <= 1'b0;
            align_q         <= 1'b0;
            load_q          <= 1'b0;
            timer_set_d1    <= 1'b0;
            timer_active    <= 1'b0;
            ecall_active    <= 1'b0;
            restart_pending <= 1'b0;
        end else begin
            ecall_q      <= ~ctl.clear_trap & (ecall_q | req.ecall);
            ebreak_q     <= ~ctl.clear_trap & (ebreak_q | req.ebreak);
            jump_mis_q   <= ~ctl.clear_trap & (jump_mis_q | ctl.misalign_jump);
            align_q      <= ~ctl.clear_trap & (align_q | req.misalign);
            timer_set_d1 <= ctl.set_timer_int;
            if (ctl.mem_begin) begin
                load_q <= ctl.load_phase;
            end
            if (ctl.set_timer_int) begin
                timer_active <= 1'b1;
            end else if (mret_active) begin
                timer_active <= 1'b0;
            end
            if (req.ecall) begin
                ecall_active <= 1'b1;
            end else if (mret_active) begin
                ecall_active <= 1'b0;
            end
            // a restart address is in flight until the first execute
            if (fetch_init) begin
                restart_pending <= 1'b1;
            end else if (ctl.exe_enable) begin
                restart_pending <= 1'b0;
            end
        end
    end

    // ==================================================================
    // trap report
    // ==================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            report <= '0;
        end else begin
            report.activate <= ctl.enter_trap;

            if (req.ebreak || req.ecall || ctl.misalign_jump) begin
                report.pc <= pc_in;
            end else if (req.misalign) begin
                report.pc <= pc_mem;
            end else if (ctl.set_timer_int) begin
                report.pc <= (restart_pending || fetch_init) ? fetch_start_addr
                                                             : pc_in + INSTR_BYTES;
            end

            if (ctl.misalign_jump) begin
                report.addr <= {jump_target[`CTL_PC_BITS-1:1], 1'b0};
            end else if (req.misalign) begin
                report.addr <= mem_addr[`CTL_PC_BITS-1:0];
            end

            // fixed priority, timer first
            report.is_interrupt <= timer_set_d1;
            if (timer_set_d1) begin
                report.code <= CAUSE_M_TIMER;
            end else if (ecall_q) begin
                report.code <= CAUSE_ECALL_M;
            end else if (ebreak_q) begin
                report.code <= CAUSE_BREAKPOINT;
            end else if (jump_mis_q) begin
                report.code <= CAUSE_INSTR_MISALIGN;
            end else if (align_q) begin
                report.code <= load_q ? CAUSE_LOAD_MISALIGN : CAUSE_STORE_MISALIGN;
            end
        end
    end

    // direct mode jumps to mtvec, vectored mode indexes by cause
    assign vec_base = {mtvec_in.f.base, 2'b00};

    always_comb begin
        if (mtvec_in.f.mode == 2'b00) begin
            vector = mtvec_in.raw[`CTL_PC_BITS-1:0];
        end else begin
            vector = vec_base[`CTL_PC_BITS-1:0]
                   + ({{(`CTL_PC_BITS-`CTL_CAUSE_BITS){1'b0}}, report.code}
                      << `CTL_VEC_STRIDE_SHIFT);
        end
    end

endmodule

`default_nettype wire

// File: design/seq_fsm.sv
// instruction sequencing FSM issuing fetch, execute, data-access and trap strobes
`default_nettype none

module seq_fsm (
    input  logic                clk,
    input  logic                reset_n,
    input  logic                start,
    input  logic                mem_read_ack,
    input  seq_pkg::dec_info_t  dec,
    input  seq_pkg::jump_req_t  jump,
    input  logic                mret_active,
    input  logic                load_done,
    input  logic                store_done,
    input  logic                timer_triggered,
    input  logic                trap_pending,
    input  logic                int_block,
    input  logic                fetch_active,
    input  logic                first_exe,
    output seq_pkg::fsm_ctl_t   ctl,
    output logic                exe_enable,
    output logic                data_access_enable,
    output logic                paused
);

    import seq_pkg::*;

    state_vec_t state;
    state_vec_t next_state;

    logic disable_access;
    logic disable_access_q;
    logic back_to_exe;
    logic back_to_exe_d1;
    logic back_to_exe_d2;
    logic mem_read_ack_d1;
    logic dec_enable_d1;

    // ==================================================================
    // state register and delay lines
    // ==================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state            <= state_vec_t'(1) << IDLE;
            disable_access_q <= 1'b0;
            back_to_exe_d1   <= 1'b0;
            back_to_exe_d2   <= 1'b0;
            mem_read_ack_d1  <= 1'b0;
            dec_enable_d1    <= 1'b0;
        end else begin
            state            <= next_state;
            disable_access_q <= disable_access;
            back_to_exe_d1   <= back_to_exe;
            back_to_exe_d2   <= back_to_exe_d1;
            mem_read_ack_d1  <= mem_read_ack;
            dec_enable_d1    <= dec.enable_out;
        end
    end

    // ==================================================================
    // next state and strobe decode
    // ==================================================================
    always_comb begin
        next_state         = '0;
        ctl                = '0;
        data_access_enable = 1'b0;
        disable_access     = 1'b0;
        back_to_exe        = 1'b0;
        paused             = 1'b0;

        case (1'b1)
            state[IDLE]: begin
                paused = 1'b1;
                if (start) begin
                    ctl.pc_init             = 1'b1;
                    next_state[REINIT_WAIT] = 1'b1;
                end else begin
                    next_state[IDLE] = 1'b1;
                end
            end
            state[REINIT_WAIT]: next_state[FETCH] = 1'b1;
            state[FETCH]:       next_state[DECODE] = 1'b1;
            state[DECODE]: begin
                if (mem_read_ack) begin
                    ctl.fetch_enable      = 1'b1;
                    next_state[FETCH_EXE] = 1'b1;
                end else begin
                    next_state[DECODE] = 1'b1;
                end
            end
            state[FETCH_EXE]: begin
                // no data access right after a return from load or store
                data_access_enable = first_exe & ~disable_access_q;
                if (timer_triggered && !int_block) begin
                    ctl.set_timer_int = 1'b1;
                    next_state[TRAP]  = 1'b1;
                end else if (jump.active && jump.target[1]) begin
                    ctl.misalign_jump = 1'b1;
                    next_state[TRAP]  = 1'b1;
                end else if (trap_pending && data_access_enable) begin
                    next_state[TRAP] = 1'b1;
                end else if (jump.active || mret_active) begin
                    ctl.jump_init           = jump.active;
                    ctl.mret_init           = mret_active & ~jump.active;
                    next_state[REINIT_WAIT] = 1'b1;
                end else begin
                    next_state[DECODE_DATA] = 1'b1;
                end
            end
            state[DECODE_DATA]: begin
                // stretched so a late decode or a load/store return still executes
                ctl.exe_enable = dec.enable_out | dec_enable_d1 | back_to_exe_d2;
                disable_access = ~ctl.exe_enable;
                if (ctl.exe_enable && dec.store) begin
                    next_state[STORE] = 1'b1;
                end else if (ctl.exe_enable && dec.load) begin
                    next_state[LOAD] = 1'b1;
                end else begin
                    ctl.fetch_enable      = ~ctl.exe_enable & (mem_read_ack | mem_read_ack_d1);
                    next_state[FETCH_EXE] = 1'b1;
                end
            end
            state[STORE], state[LOAD]: begin
                // data phase waits for the bus to finish the fetch
                if (!fetch_active) begin
                    data_access_enable = 1'b1;
                    ctl.mem_begin      = 1'b1;
                    ctl.load_phase     = state[LOAD];
                    next_state[state[LOAD] ? LOAD_WAIT : STORE_WAIT] = 1'b1;
                end else begin
                    next_state = state;
                end
            end
            state[STORE_WAIT], state[LOAD_WAIT]: begin
                if (trap_pending) begin
                    next_state[TRAP] = 1'b1;
                end else if (state[LOAD_WAIT] ? load_done : store_done) begin
                    ctl.fetch_enable      = 1'b1;
                    disable_access        = 1'b1;
                    back_to_exe           = 1'b1;
                    next_state[FETCH_EXE] = 1'b1;
                end else begin
                    next_state = state;
                end
            end
            state[TRAP]: begin
                ctl.enter_trap          = 1'b1;
                next_state[TRAP_REINIT] = 1'b1;
            end
            state[TRAP_REINIT]: begin
                ctl.trap_init           = 1'b1;
                ctl.clear_trap          = 1'b1;
                next_state[REINIT_WAIT] = 1'b1;
            end
            default: next_state[IDLE] = 1'b1;
        endcase
    end

    assign exe_enable = ctl.exe_enable;

endmodule

`default_nettype wire

// File: design/seq_pkg.sv
// sequencing types: state indices, decode info, jump request and FSM strobes
`default_nettype none

`include "ctl_cfg.svh"

package seq_pkg;

    localparam int STATE_COUNT = 12;

    // bit positions in the one-hot state vector
    typedef enum int unsigned {
        IDLE        = 0,
        REINIT_WAIT = 1,
        FETCH       = 2,
        DECODE      = 3,
        FETCH_EXE   = 4,
        DECODE_DATA = 5,
        STORE       = 6,
        STORE_WAIT  = 7,
        LOAD        = 8,
        LOAD_WAIT   = 9,
        TRAP        = 10,
        TRAP_REINIT = 11
    } state_idx_e;

    typedef logic [STATE_COUNT-1:0] state_vec_t;

    typedef struct packed {
        logic enable_out;
        logic load;
        logic store;
    } dec_info_t;

    // JAL, JALR and taken branches all arrive here
    typedef struct packed {
        logic                    active;
        logic [`CTL_PC_BITS-1:0] target;
    } jump_req_t;

    // one-cycle strobes from the FSM to trap unit and fetch redirect
    typedef struct packed {
        logic pc_init;
        logic jump_init;
        logic mret_init;
        logic trap_init;
        logic fetch_enable;
        logic exe_enable;
        logic mem_begin;
        logic load_phase;
        logic set_timer_int;
        logic misalign_jump;
        logic enter_trap;
        logic clear_trap;
    } fsm_ctl_t;

endpackage

`default_nettype wire

// File: design/trap_pkg.sv
// trap types: cause codes, trap request and report, mtvec views
`default_nettype none

`include "ctl_cfg.svh"

package trap_pkg;

    // machine mode cause codes (interrupt bit travels separately)
    typedef enum logic [`CTL_CAUSE_BITS-1:0] {
        CAUSE_INSTR_MISALIGN = 'd0,
        CAUSE_BREAKPOINT     = 'd3,
        CAUSE_LOAD_MISALIGN  = 'd4,
        CAUSE_STORE_MISALIGN = 'd6,
        CAUSE_M_TIMER        = 'd7,
        CAUSE_ECALL_M        = 'd11
    } cause_e;

    // exception requests seen in the execute stage
    typedef struct packed {
        logic ecall;
        logic ebreak;
        logic misalign;
    } trap_req_t;

    // what goes to the CSR file when a trap is taken
    typedef struct packed {
        logic                     activate;
        logic                     is_interrupt;
        cause_e                   code;
        logic [`CTL_PC_BITS-1:0]  pc;
        logic [`CTL_PC_BITS-1:0]  addr;
    } trap_report_t;

    // mtvec, as a whole word for direct mode or split for vectored mode
    typedef union packed {
        logic [`CTL_XLEN-1:0] raw;
        struct packed {
            logic [`CTL_XLEN-3:0] base;
            logic [1:0]           mode;
        } f;
    } mtvec_u;

endpackage

`default_nettype wire

// File: design/ctl_cfg.svh
// sequencing controller configuration: datapath widths and trap vector spacing
`ifndef CTL_CFG_SVH
`define CTL_CFG_SVH

// program counter width
`define CTL_PC_BITS 32

// data word width, also the width of mtvec
`define CTL_XLEN 32

// width of the mcause exception code field
`define CTL_CAUSE_BITS 4

// log2 of the byte spacing between vectored trap entries
`define CTL_VEC_STRIDE_SHIFT 2

`endif
